// ==== hw/dvi_pkg.sv ====
// Shared 640x480p60 timing constants and video types, imported by every DVI transmit module

`default_nettype none

package dvi_pkg;

	// --------------------------------------------------
	// Types

	typedef logic [10:0]        coord_t;     // h, v and frame counts
	typedef logic [7:0]         pixel_t;     // One colour component
	typedef logic [9:0]         tmds_sym_t;  // Parallel TMDS symbol, bit 0 sent first
	typedef logic signed [4:0]  disparity_t; // Running ones minus zeros

	// Phase order within a line, and within a frame in lines
	typedef enum logic [1:0] {
		PH_ACTIVE = 2'd0,
		PH_FRONT  = 2'd1,
		PH_SYNC   = 2'd2,
		PH_BACK   = 2'd3
	} timing_phase_t;

	// --------------------------------------------------
	// CEA-861D 640x480p 60 Hz

	// Horizontal, in pixels
	localparam coord_t H_ACTIVE = 11'd640;
	localparam coord_t H_FRONT  = 11'd16;
	localparam coord_t H_SYNC   = 11'd96;
	localparam coord_t H_BACK   = 11'd48;
	localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

	// Vertical, in lines
	localparam coord_t V_ACTIVE = 11'd480;
	localparam coord_t V_FRONT  = 11'd10;
	localparam coord_t V_SYNC   = 11'd2;
	localparam coord_t V_BACK   = 11'd33;
	localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

	// Both syncs are negative for this mode
	localparam logic SYNC_ACTIVE_LEVEL = 1'b0;

	// --------------------------------------------------
	// TMDS control symbols, indexed by {c1, c0}

	localparam tmds_sym_t CTRL_SYM_00 = 10'b1101010100;
	localparam tmds_sym_t CTRL_SYM_01 = 10'b0010101011;
	localparam tmds_sym_t CTRL_SYM_10 = 10'b0101010100;
	localparam tmds_sym_t CTRL_SYM_11 = 10'b1010101011;

endpackage

`default_nettype wire

// ==== hw/dvi_tx_top.sv ====
// DVI transmit top level, test pattern through 640x480p60 timing into parallel TMDS symbols

`default_nettype none

module dvi_tx_top (
	input  wire logic          i_clk_dvi_pix,
	input  wire logic          i_rst_n_dvi_pix,
	output dvi_pkg::tmds_sym_t o_tmds0,
	output dvi_pkg::tmds_sym_t o_tmds1,
	output dvi_pkg::tmds_sym_t o_tmds2
);

	import dvi_pkg::*;

	// --------------------------------------------------
	// Pixel path wiring

	logic   rgb_rdy;
	logic   de;
	logic   hsync;
	logic   vsync;
	pixel_t red;
	pixel_t green;
	pixel_t blue;

	test_pattern_gen u_pattern (
		.i_clk_dvi_pix   (i_clk_dvi_pix),
		.i_rst_n_dvi_pix (i_rst_n_dvi_pix),
		.i_rgb_rdy       (rgb_rdy),
		.o_red           (red),
		.o_green         (green),
		.o_blue          (blue)
	);

	video_timing u_timing (
		.i_clk_dvi_pix   (i_clk_dvi_pix),
		.i_rst_n_dvi_pix (i_rst_n_dvi_pix),
		.o_de            (de),
		.o_hsync         (hsync),
		.o_vsync         (vsync),
		.o_rgb_rdy       (rgb_rdy)
	);

	tmds_encoder_bank u_encoders (
		.i_clk_dvi_pix   (i_clk_dvi_pix),
		.i_rst_n_dvi_pix (i_rst_n_dvi_pix),
		.i_de            (de),
		.i_hsync         (hsync),
		.i_vsync         (vsync),
		.i_red           (red),
		.i_green         (green),
		.i_blue          (blue),
		.o_tmds0         (o_tmds0),  // Blue plus syncs
		.o_tmds1         (o_tmds1),
		.o_tmds2         (o_tmds2)
	);

endmodule

`default_nettype wire

// ==== hw/test_pattern_gen.sv ====
// Moving RGB test pattern source, pulled one pixel per cycle by the timing block's ready strobe

`default_nettype none

module test_pattern_gen (
	input  wire logic          i_clk_dvi_pix,
	input  wire logic          i_rst_n_dvi_pix,
	input  wire logic          i_rgb_rdy,
	output dvi_pkg::pixel_t    o_red,
	output dvi_pkg::pixel_t    o_green,
	output dvi_pkg::pixel_t    o_blue
);

	import dvi_pkg::*;

	coord_t h_ctr;     // Active pixel within line
	coord_t v_ctr;     // Active line within frame
	coord_t frame_ctr;
	coord_t red_sum;
	coord_t green_sum;

	// --------------------------------------------------
	// Counters advance only on consumed pixels

	always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
		if (!i_rst_n_dvi_pix) begin
			h_ctr     <= '0;
			v_ctr     <= '0;
			frame_ctr <= '0;
		end else if (i_rgb_rdy) begin
			if (h_ctr == H_ACTIVE - 1'b1) begin
				h_ctr <= '0;
				if (v_ctr == V_ACTIVE - 1'b1) begin
					v_ctr     <= '0;
					frame_ctr <= frame_ctr + 1'b1; // After last pixel of line 479
				end else begin
					v_ctr <= v_ctr + 1'b1;
				end
			end else begin
				h_ctr <= h_ctr + 1'b1;
			end
		end
	end

	// Pattern scrolls diagonally as the frame count rises
	assign red_sum   = h_ctr + frame_ctr;
	assign green_sum = v_ctr + frame_ctr;

	assign o_red   = pixel_t'(red_sum << 2);   // Keep low 8 bits of sum x 4
	assign o_green = pixel_t'(green_sum << 2);
	assign o_blue  = frame_ctr[7:0];

endmodule

`default_nettype wire

// ==== hw/tmds_encoder_bank.sv ====
// Three-channel TMDS 8b/10b encoder with DC balance, registered symbols for the DVI link

`default_nettype none

module tmds_encoder_bank (
	input  wire logic          i_clk_dvi_pix,
	input  wire logic          i_rst_n_dvi_pix,
	input  wire logic          i_de,
	input  wire logic          i_hsync,
	input  wire logic          i_vsync,
	input  dvi_pkg::pixel_t    i_red,
	input  dvi_pkg::pixel_t    i_green,
	input  dvi_pkg::pixel_t    i_blue,
	output dvi_pkg::tmds_sym_t o_tmds0,
	output dvi_pkg::tmds_sym_t o_tmds1,
	output dvi_pkg::tmds_sym_t o_tmds2
);

	import dvi_pkg::*;

	pixel_t     chan_d [3]; // Blue, green, red
	tmds_sym_t  sym_d  [3];
	tmds_sym_t  sym_q  [3];
	disparity_t disp_d [3];
	disparity_t disp_q [3];

	// --------------------------------------------------
	// 8b/10b data encoding

	function automatic tmds_sym_t tmds_encode(
		input  pixel_t     d,
		input  disparity_t disp_in,
		output disparity_t disp_out
	);
		logic [3:0] n1_d;
		logic [3:0] n1_q;
		logic [8:0] q_m;
		logic       use_xnor;
		disparity_t bal;
		tmds_sym_t  sym;

		// Transition minimisation
		n1_d     = 4'($countones(d));
		use_xnor = n1_d > 4'd4 || (n1_d == 4'd4 && !d[0]);
		q_m[0]   = d[0];
		for (int i = 1; i < 8; i++) begin
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
		end
		q_m[8] = ~use_xnor;

		// Ones minus zeros of the minimised byte
		n1_q = 4'($countones(q_m[7:0]));
		bal  = (disparity_t'({1'b0, n1_q}) <<< 1) - disparity_t'(8);

		if (disp_in == 0 || bal == 0) begin
			sym      = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
			disp_out = q_m[8] ? disp_in + bal : disp_in - bal;
		end else if ((disp_in > 0 && bal > 0) || (disp_in < 0 && bal < 0)) begin
			sym      = {1'b1, q_m[8], ~q_m[7:0]}; // Invert to pull back towards zero
			disp_out = disp_in - bal + (q_m[8] ? disparity_t'(2) : disparity_t'(0));
		end else begin
			sym      = {1'b0, q_m[8], q_m[7:0]};
			disp_out = disp_in + bal - (q_m[8] ? disparity_t'(0) : disparity_t'(2));
		end
		return sym;
	endfunction

	function automatic tmds_sym_t ctrl_sym(input logic [1:0] c);
		case (c)
			2'b00:   ctrl_sym = CTRL_SYM_00;
			2'b01:   ctrl_sym = CTRL_SYM_01;
			2'b10:   ctrl_sym = CTRL_SYM_10;
			default: ctrl_sym = CTRL_SYM_11;
		endcase
	endfunction

	assign chan_d[0] = i_blue;
	assign chan_d[1] = i_green;
	assign chan_d[2] = i_red;

	always_comb begin
		for (int ch = 0; ch < 3; ch++) begin
			sym_d[ch] = tmds_encode(chan_d[ch], disp_q[ch], disp_d[ch]);
		end
	end

	// --------------------------------------------------
	// Output and disparity registers

	always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
		if (!i_rst_n_dvi_pix) begin
			sym_q[0] <= CTRL_SYM_11; // Syncs inactive
			sym_q[1] <= CTRL_SYM_00;
			sym_q[2] <= CTRL_SYM_00;
			for (int ch = 0; ch < 3; ch++) begin
				disp_q[ch] <= '0;
			end
		end else if (i_de) begin
			for (int ch = 0; ch < 3; ch++) begin
				sym_q[ch]  <= sym_d[ch];
				disp_q[ch] <= disp_d[ch];
			end
		end else begin
			sym_q[0] <= ctrl_sym({i_vsync, i_hsync}); // Syncs ride on blue only
			sym_q[1] <= CTRL_SYM_00;
			sym_q[2] <= CTRL_SYM_00;
			for (int ch = 0; ch < 3; ch++) begin
				disp_q[ch] <= '0;
			end
		end
	end

	assign o_tmds0 = sym_q[0];
	assign o_tmds1 = sym_q[1];
	assign o_tmds2 = sym_q[2];

	for (genvar ch = 0; ch < 3; ch++) begin : g_disp_chk
		a_disp_range: assert property (@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
			disp_q[ch] <= 10 && disp_q[ch] >= -10);
	end

endmodule

`default_nettype wire

// ==== hw/video_timing.sv ====
// Timing master for 640x480p60, produces data enable, syncs and the pixel ready strobe per cycle

`default_nettype none

module video_timing (
	input  wire logic i_clk_dvi_pix,
	input  wire logic i_rst_n_dvi_pix,
	output logic      o_de,
	output logic      o_hsync,
	output logic      o_vsync,
	output logic      o_rgb_rdy
);

	import dvi_pkg::*;

	timing_phase_t h_phase;
	timing_phase_t v_phase;
	coord_t        h_ctr;    // Pixel within current horizontal phase
	coord_t        v_ctr;    // Line within current vertical phase
	logic          h_last;
	logic          v_last;
	logic          line_end;

	// Length of a phase, in pixels or in lines
	function automatic coord_t phase_len(input timing_phase_t ph, input logic vert);
		case (ph)
			PH_ACTIVE: phase_len = vert ? V_ACTIVE : H_ACTIVE;
			PH_FRONT:  phase_len = vert ? V_FRONT  : H_FRONT;
			PH_SYNC:   phase_len = vert ? V_SYNC   : H_SYNC;
			default:   phase_len = vert ? V_BACK   : H_BACK;
		endcase
	endfunction

	function automatic timing_phase_t next_phase(input timing_phase_t ph);
		case (ph)
			PH_ACTIVE: next_phase = PH_FRONT;
			PH_FRONT:  next_phase = PH_SYNC;
			PH_SYNC:   next_phase = PH_BACK;
			default:   next_phase = PH_ACTIVE;
		endcase
	endfunction

	assign h_last   = h_ctr == phase_len(h_phase, 1'b0) - 1'b1;
	assign v_last   = v_ctr == phase_len(v_phase, 1'b1) - 1'b1;
	assign line_end = h_last && h_phase == PH_BACK; // Last pixel of the back porch

	// --------------------------------------------------
	// Phase sequencers

	always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
		if (!i_rst_n_dvi_pix) begin
			h_phase <= PH_ACTIVE;
			h_ctr   <= '0;
			v_phase <= PH_ACTIVE;
			v_ctr   <= '0;
		end else begin
			if (h_last) begin
				h_phase <= next_phase(h_phase);
				h_ctr   <= '0;
			end else begin
				h_ctr <= h_ctr + 1'b1;
			end

			// Vertical steps once per line
			if (line_end) begin
				if (v_last) begin
					v_phase <= next_phase(v_phase);
					v_ctr   <= '0;
				end else begin
					v_ctr <= v_ctr + 1'b1;
				end
			end
		end
	end

	// --------------------------------------------------
	// Outputs straight from phase state

	assign o_de      = h_phase == PH_ACTIVE && v_phase == PH_ACTIVE;
	assign o_rgb_rdy = o_de; // Encoder takes a pixel every active cycle
	assign o_hsync   = (h_phase == PH_SYNC) ? SYNC_ACTIVE_LEVEL : ~SYNC_ACTIVE_LEVEL;
	assign o_vsync   = (v_phase == PH_SYNC) ? SYNC_ACTIVE_LEVEL : ~SYNC_ACTIVE_LEVEL;

	// Pixel pulls start only as a new line begins
	a_rdy_line_start: assert property (@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
		$rose(o_rgb_rdy) |-> $past(line_end));

	// Sync pulse begins only after a front porch
	a_hsync_phase: assert property (@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
		o_hsync == SYNC_ACTIVE_LEVEL |-> h_phase == PH_SYNC
			&& (h_ctr != '0 || $past(h_phase) == PH_FRONT));

	a_ctr_bound: assert property (@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
		h_ctr < phase_len(h_phase, 1'b0) && v_ctr < phase_len(v_phase, 1'b1));

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tests
hw/dvi_pkg.sv
hw/test_pattern_gen.sv
hw/video_timing.sv
hw/tmds_encoder_bank.sv
hw/dvi_tx_top.sv
tests/tb_dvi_tx.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dvi_tx \
	-Mdir obj_dir -f list.f &&
	./obj_dir/Vtb_dvi_tx > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
echo "Simulation passed"
exit 0

// ==== tests/tb_tmds_model.svh ====
// Reference model of pattern, raster timing and TMDS coding plus compare tasks, included by tb_dvi_tx
`ifndef TB_TMDS_MODEL_SVH
`define TB_TMDS_MODEL_SVH

	// --------------------------------------------------
	// Model state, raster position of the next symbol

	int m_frame;
	int m_line;
	int m_col;
	int m_disp [3]; // Ones minus zeros sent, per channel

	function automatic bit is_ctrl(input tmds_sym_t s);
		return s == CTRL_SYM_00 || s == CTRL_SYM_01 || s == CTRL_SYM_10 || s == CTRL_SYM_11;
	endfunction

	function automatic pixel_t decode_sym(input tmds_sym_t s);
		logic [7:0] q;
		pixel_t     d;
		q    = s[9] ? ~s[7:0] : s[7:0]; // Undo DC balance inversion
		d[0] = q[0];
		for (int i = 1; i < 8; i++) begin
			d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		end
		return d;
	endfunction

	// DVI 1.0 encoder, counts kept as plain integers
	task automatic encode_model(input pixel_t d, input int ch, output tmds_sym_t sym);
		int         n1_d;
		int         n1_m;
		int         n0_m;
		logic [8:0] q_m;
		logic       use_xnor;
		n1_d = 0;
		n1_m = 0;
		for (int i = 0; i < 8; i++) begin
			n1_d = n1_d + int'(d[i]);
		end
		use_xnor = n1_d > 4 || (n1_d == 4 && d[0] == 1'b0);
		q_m[0]   = d[0];
		for (int i = 1; i < 8; i++) begin
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
		end
		q_m[8] = !use_xnor;
		for (int i = 0; i < 8; i++) begin
			n1_m = n1_m + int'(q_m[i]);
		end
		n0_m = 8 - n1_m;
		if (m_disp[ch] == 0 || n1_m == n0_m) begin
			sym        = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
			m_disp[ch] = m_disp[ch] + (q_m[8] ? n1_m - n0_m : n0_m - n1_m);
		end else if ((m_disp[ch] > 0 && n1_m > n0_m) || (m_disp[ch] < 0 && n0_m > n1_m)) begin
			sym        = {1'b1, q_m[8], ~q_m[7:0]};
			m_disp[ch] = m_disp[ch] + 2 * int'(q_m[8]) + n0_m - n1_m;
		end else begin
			sym        = {1'b0, q_m[8], q_m[7:0]};
			m_disp[ch] = m_disp[ch] - 2 * int'(!q_m[8]) + n1_m - n0_m;
		end
	endtask

	// --------------------------------------------------
	// Compare tasks

	task automatic check_sym(input string name, input tmds_sym_t exp_val, input tmds_sym_t act);
		if (act !== exp_val) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp_val, act));
		end
	endtask

	task automatic check_count(input string name, input coord_t exp_val, input coord_t act);
		if (act !== exp_val) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp_val, act));
		end
	endtask

	task automatic check_pixel(input string name, input pixel_t exp_val, input pixel_t act);
		if (act !== exp_val) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp_val, act));
		end
	endtask

`endif

// ==== tests/tb_dvi_tx.sv ====
// Directed testbench for the DVI transmit top, two frames of symbols checked against a software model

`default_nettype none

module tb_dvi_tx;

	import dvi_pkg::*;

	localparam int FRAME_SYMS     = int'(H_TOTAL) * int'(V_TOTAL);
	localparam int TIMEOUT_CYCLES = 3 * FRAME_SYMS + 100; // Two frames run, one spare

	logic      clk_dvi_pix;
	logic      rst_n_dvi_pix;
	tmds_sym_t tmds0;
	tmds_sym_t tmds1;
	tmds_sym_t tmds2;
	tmds_sym_t obs     [3]; // Sampled DUT symbols
	tmds_sym_t exp_sym [3];
	int        cycle_count;

	dvi_tx_top DUT (
		.i_clk_dvi_pix   (clk_dvi_pix),
		.i_rst_n_dvi_pix (rst_n_dvi_pix),
		.o_tmds0         (tmds0),
		.o_tmds1         (tmds1),
		.o_tmds2         (tmds2)
	);

	`include "tb_tmds_model.svh"

	always #50 clk_dvi_pix = ~clk_dvi_pix;

	always @(posedge clk_dvi_pix) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_failure("Timeout: the run did not finish within the cycle limit");
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// --------------------------------------------------
	// Model stepping and sampling

	task automatic model_step(output tmds_sym_t e0, output tmds_sym_t e1, output tmds_sym_t e2);
		logic de;
		logic hs;
		logic vs;
		de = m_col < H_ACTIVE && m_line < V_ACTIVE;
		hs = (m_col >= H_ACTIVE + H_FRONT && m_col < H_ACTIVE + H_FRONT + H_SYNC)
			? SYNC_ACTIVE_LEVEL : !SYNC_ACTIVE_LEVEL;
		vs = (m_line >= V_ACTIVE + V_FRONT && m_line < V_ACTIVE + V_FRONT + V_SYNC)
			? SYNC_ACTIVE_LEVEL : !SYNC_ACTIVE_LEVEL;
		if (de) begin
			encode_model(pixel_t'(m_frame), 0, e0);
			encode_model(pixel_t'((m_line + m_frame) * 4), 1, e1);
			encode_model(pixel_t'((m_col + m_frame) * 4), 2, e2);
		end else begin
			case ({vs, hs})
				2'b00:   e0 = CTRL_SYM_00;
				2'b01:   e0 = CTRL_SYM_01;
				2'b10:   e0 = CTRL_SYM_10;
				default: e0 = CTRL_SYM_11;
			endcase
			e1     = CTRL_SYM_00;
			e2     = CTRL_SYM_00;
			m_disp = '{0, 0, 0}; // Balance restarts after blanking
		end
		m_col++;
		if (m_col == H_TOTAL) begin
			m_col = 0;
			m_line++;
			if (m_line == V_TOTAL) begin
				m_line = 0;
				m_frame++;
			end
		end
	endtask

	task automatic next_sym();
		@(posedge clk_dvi_pix);
		#1;
		obs[0] = tmds0;
		obs[1] = tmds1;
		obs[2] = tmds2;
		model_step(exp_sym[0], exp_sym[1], exp_sym[2]);
	endtask

	task automatic compare_syms();
		check_sym("o_tmds0", exp_sym[0], obs[0]);
		check_sym("o_tmds1", exp_sym[1], obs[1]);
		check_sym("o_tmds2", exp_sym[2], obs[2]);
	endtask

	// --------------------------------------------------
	// Directed tests

	task automatic test_reset_symbols();
		check_sym("o_tmds0", CTRL_SYM_11, tmds0);
		check_sym("o_tmds1", CTRL_SYM_00, tmds1);
		check_sym("o_tmds2", CTRL_SYM_00, tmds2);
	endtask

	task automatic test_line_zero();
		coord_t hs_syms;
		coord_t data_syms;
		hs_syms   = '0;
		data_syms = '0;
		for (int col = 0; col < H_TOTAL; col++) begin
			next_sym();
			compare_syms();
			if (obs[0] == CTRL_SYM_00 || obs[0] == CTRL_SYM_10) begin
				hs_syms++;
			end
			if (!is_ctrl(obs[0])) begin
				data_syms++;
			end
		end
		check_count("hsync low symbols", H_SYNC, hs_syms);
		check_count("line 0 data symbols", H_ACTIVE, data_syms);
	endtask

	task automatic test_frame_zero_rest();
		coord_t data_syms;
		coord_t active_lines;
		coord_t vs_syms;
		coord_t first_vs_line;
		int     hs_start;
		int     sym_idx;
		logic   hs_low;
		logic   hs_low_prev;
		active_lines  = coord_t'(1); // Line 0 already seen
		vs_syms       = '0;
		first_vs_line = '0;
		hs_start      = -1;
		sym_idx       = 0;
		hs_low_prev   = 1'b0;
		for (int line = 1; line < V_TOTAL; line++) begin
			data_syms = '0;
			for (int col = 0; col < H_TOTAL; col++) begin
				next_sym();
				compare_syms();
				hs_low = obs[0] == CTRL_SYM_00 || obs[0] == CTRL_SYM_10;
				if (hs_low && !hs_low_prev) begin
					if (hs_start >= 0) begin
						check_count("line period", H_TOTAL, coord_t'(sym_idx - hs_start));
					end
					hs_start = sym_idx;
				end
				hs_low_prev = hs_low;
				if (!is_ctrl(obs[0])) begin
					data_syms++;
				end
				if (obs[0] == CTRL_SYM_00 || obs[0] == CTRL_SYM_01) begin
					if (vs_syms == 0) begin
						first_vs_line = coord_t'(line);
					end
					vs_syms++;
				end
				sym_idx++;
			end
			check_count("data symbols per line", (line < V_ACTIVE) ? H_ACTIVE : coord_t'(0),
				data_syms);
			if (data_syms != 0) begin
				active_lines++;
			end
		end
		check_count("active lines", V_ACTIVE, active_lines);
		check_count("vsync symbols", V_SYNC * H_TOTAL, vs_syms);
		check_count("first vsync line", V_ACTIVE + V_FRONT, first_vs_line);
	endtask

	// Frame count moves the pattern by one step
	task automatic test_frame_one_first_line();
		next_sym();
		compare_syms();
		check_pixel("decoded red", 8'd4, decode_sym(obs[2]));
		check_pixel("decoded green", 8'd4, decode_sym(obs[1]));
		check_pixel("decoded blue", 8'd1, decode_sym(obs[0]));
		for (int col = 1; col < H_TOTAL; col++) begin
			next_sym();
			compare_syms();
		end
	endtask

	task automatic test_frame_one_rest();
		for (int n = H_TOTAL; n < FRAME_SYMS; n++) begin
			next_sym();
			compare_syms();
		end
	endtask

	initial begin
		clk_dvi_pix   = 1'b0;
		rst_n_dvi_pix = 1'b0;
		cycle_count   = 0;
		m_frame       = 0;
		m_line        = 0;
		m_col         = 0;
		m_disp        = '{0, 0, 0};
		repeat (5) @(posedge clk_dvi_pix);
		#1;
		rst_n_dvi_pix = 1'b1;
		test_reset_symbols();
		test_line_zero();
		test_frame_zero_rest();
		test_frame_one_first_line();
		test_frame_one_rest();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
